// File: logic/panel_pkg.sv
package panel_pkg;

    typedef enum logic [1:0] {
        PICK_NONE  = 2'd0,
        PICK_RED   = 2'd1,
        PICK_GREEN = 2'd2,
        PICK_BLUE  = 2'd3
    } pick_t;

    typedef logic [2:0] score_t;
    typedef logic [6:0] seg_t;        // Segments a..g, a is the MSB
    typedef logic [7:0] digit_pos_t;

    localparam digit_pos_t DIGIT_POS_P1 = 8'b0000_0001;
    localparam digit_pos_t DIGIT_POS_P2 = 8'b1000_0000;

    function automatic seg_t seg_of_score(score_t score);
        case (score)
            3'd1:    return 7'b0110000;
            3'd2:    return 7'b1101101;
            3'd3:    return 7'b1111001;
            3'd4:    return 7'b0110011;
            3'd5:    return 7'b1011011;
            default: return 7'b0000000; // Out of range scores stay dark
        endcase
    endfunction

endpackage

// File: logic/lcd_pkg.sv
package lcd_pkg;

    typedef enum logic [2:0] {
        ST_POWER_WAIT,
        ST_FUNC_SET,
        ST_ENTRY_MODE,
        ST_DISPLAY_ON,
        ST_LINE1,
        ST_LINE2,
        ST_RETURN_HOME,
        ST_CLEAR
    } lcd_state_t;

    typedef enum logic [7:0] {
        CMD_FUNC_SET    = 8'h3C,  // 8-bit bus, 2 lines, 5x11 font
        CMD_ENTRY_MODE  = 8'h06,  // Increment, no shift
        CMD_DISPLAY_ON  = 8'h0C,  // Display on, cursor off
        CMD_LINE1_ADDR  = 8'h80,
        CMD_LINE2_ADDR  = 8'hC0,
        CMD_RETURN_HOME = 8'h02,
        CMD_CLEAR       = 8'h01
    } lcd_cmd_t;

    typedef enum logic [1:0] {
        WIN_NONE = 2'd0,
        WIN_P1   = 2'd1,
        WIN_P2   = 2'd2
    } winner_t;

    typedef logic [7:0] char_t;
    typedef logic [3:0] col_t;

    localparam char_t CHAR_SPACE = 8'h20;
    localparam char_t CHAR_HEART = 8'h9D; // Heart glyph in the LCD font ROM

    localparam int LCD_COLS = 16;

endpackage

// File: logic/led_indicator.sv
`timescale 1ns/10ps

module led_indicator
    import panel_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  pick_t pick1,
    input  pick_t pick2,
    output logic  led1_r,
    output logic  led1_g,
    output logic  led1_b,
    output logic  led2_r,
    output logic  led2_g,
    output logic  led2_b
);

    logic [2:0] led1_rgb;
    logic [2:0] led2_rgb;
    logic       one_picker;

    // One-hot {r, g, b} for a pick
    function automatic logic [2:0] rgb_of(pick_t pick);
        case (pick)
            PICK_RED:   return 3'b100;
            PICK_GREEN: return 3'b010;
            PICK_BLUE:  return 3'b001;
            default:    return 3'b000;
        endcase
    endfunction

    assign one_picker = (pick1 != PICK_NONE) ^ (pick2 != PICK_NONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            led1_rgb <= 3'b000;
            led2_rgb <= 3'b000;
        end else if (one_picker) begin // Otherwise hold last lighting
            led1_rgb <= rgb_of(pick1);
            led2_rgb <= rgb_of(pick2);
        end
    end

    assign {led1_r, led1_g, led1_b} = led1_rgb;
    assign {led2_r, led2_g, led2_b} = led2_rgb;

endmodule

// File: logic/score_scanner.sv
`timescale 1ns/10ps

module score_scanner
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  score_t     score1,
    input  score_t     score2,
    output seg_t       seg,
    output digit_pos_t digit_pos
);

    logic [1:0] slot;
    score_t     cur_score;
    digit_pos_t cur_pos;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot <= 2'd0;
        end else begin
            slot <= slot + 2'd1;
        end
    end

    // Slots 2 and 3 blank the display
    always_comb begin
        case (slot)
            2'd0: begin
                cur_pos   = DIGIT_POS_P1;
                cur_score = score1;
            end
            2'd1: begin
                cur_pos   = DIGIT_POS_P2;
                cur_score = score2;
            end
            default: begin
                cur_pos   = '0;
                cur_score = '0; // Decodes to an empty pattern
            end
        endcase
    end

    // Pattern and position change on the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            seg       <= '0;
            digit_pos <= '0;
        end else begin
            seg       <= seg_of_score(cur_score);
            digit_pos <= cur_pos;
        end
    end

endmodule

// File: logic/lcd_banner.sv
`timescale 1ns/10ps

module lcd_banner
    import lcd_pkg::*;
(
    input  winner_t winner,
    input  logic    line_sel,
    input  col_t    column,
    output char_t   char_code
);

    logic  has_winner;
    char_t player_digit;

    assign has_winner   = (winner == WIN_P1) || (winner == WIN_P2);
    assign player_digit = (winner == WIN_P1) ? "1" : "2";

    always_comb begin
        char_code = CHAR_SPACE;
        if (has_winner) begin
            if (!line_sel) begin
                case (column) // "P1 Win" starting at column 2
                    4'd2:    char_code = "P";
                    4'd3:    char_code = player_digit;
                    4'd5:    char_code = "W";
                    4'd6:    char_code = "i";
                    4'd7:    char_code = "n";
                    default: char_code = CHAR_SPACE;
                endcase
            end else begin
                case (column) // Two groups of three hearts
                    4'd2, 4'd3, 4'd4,
                    4'd6, 4'd7, 4'd8: char_code = CHAR_HEART;
                    default:          char_code = CHAR_SPACE;
                endcase
            end
        end
    end

endmodule

// File: logic/lcd_sequencer.sv
`timescale 1ns/10ps

module lcd_sequencer
    import lcd_pkg::*;
#(
    parameter int POWER_WAIT_CYCLES = 70,
    parameter int CMD_CYCLES        = 30,
    parameter int LINE_CYCLES       = 21,
    parameter int HOME_CYCLES       = 400,
    parameter int CLEAR_CYCLES      = 200
) (
    input  logic  clk,
    input  logic  resetn,
    input  char_t char_code,
    output logic  line_sel,
    output col_t  column,
    output logic  lcd_e,
    output logic  lcd_rs,
    output char_t lcd_data
);

    lcd_state_t  state;
    lcd_state_t  next_state;
    logic [15:0] step;
    logic [15:0] state_len;
    logic        last_step;
    logic        wr_e;
    logic        wr_rs;
    char_t       wr_data;

    always_comb begin
        case (state)
            ST_POWER_WAIT:  state_len = 16'(POWER_WAIT_CYCLES);
            ST_LINE1,
            ST_LINE2:       state_len = 16'(LINE_CYCLES);
            ST_RETURN_HOME: state_len = 16'(HOME_CYCLES);
            ST_CLEAR:       state_len = 16'(CLEAR_CYCLES);
            default:        state_len = 16'(CMD_CYCLES);
        endcase
    end

    assign last_step = (step == state_len - 16'd1);

    always_comb begin
        case (state)
            ST_POWER_WAIT:  next_state = ST_FUNC_SET;
            ST_FUNC_SET:    next_state = ST_ENTRY_MODE;
            ST_ENTRY_MODE:  next_state = ST_DISPLAY_ON;
            ST_DISPLAY_ON:  next_state = ST_LINE1;
            ST_LINE1:       next_state = ST_LINE2;
            ST_LINE2:       next_state = ST_RETURN_HOME;
            ST_RETURN_HOME: next_state = ST_CLEAR;
            default:        next_state = ST_LINE1; // Refresh loop
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_POWER_WAIT;
            step  <= '0;
        end else if (last_step) begin
            state <= next_state;
            step  <= '0;
        end else begin
            step <= step + 16'd1;
        end
    end

    // Banner address, column is valid for steps 1..16
    assign line_sel = (state == ST_LINE2);
    assign column   = col_t'(step - 16'd1);

    always_comb begin
        wr_e    = 1'b0;
        wr_rs   = 1'b0;
        wr_data = '0;
        case (state)
            ST_FUNC_SET:    wr_data = CMD_FUNC_SET;
            ST_ENTRY_MODE:  wr_data = CMD_ENTRY_MODE;
            ST_DISPLAY_ON:  wr_data = CMD_DISPLAY_ON;
            ST_RETURN_HOME: wr_data = CMD_RETURN_HOME;
            ST_CLEAR:       wr_data = CMD_CLEAR;
            ST_LINE1:       wr_data = CMD_LINE1_ADDR;
            ST_LINE2:       wr_data = CMD_LINE2_ADDR;
            default:        wr_data = '0;
        endcase
        if (state != ST_POWER_WAIT && step == 16'd0) begin
            wr_e = 1'b1; // One command write per state
        end else if ((state == ST_LINE1 || state == ST_LINE2) &&
                     step <= 16'(LCD_COLS)) begin
            wr_e    = 1'b1;
            wr_rs   = 1'b1;
            wr_data = char_code;
        end else begin
            wr_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else begin
            lcd_e    <= wr_e;
            lcd_rs   <= wr_rs;
            lcd_data <= wr_data;
        end
    end

endmodule

// File: logic/game_panel_top.sv
`timescale 1ns/10ps

module game_panel_top
    import panel_pkg::*;
    import lcd_pkg::*;
#(
    parameter int POWER_WAIT_CYCLES = 70,
    parameter int CMD_CYCLES        = 30,
    parameter int LINE_CYCLES       = 21,  // Needs at least 17
    parameter int HOME_CYCLES       = 400,
    parameter int CLEAR_CYCLES      = 200
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic [1:0] pick1,
    input  logic [1:0] pick2,
    input  logic [2:0] score1,
    input  logic [2:0] score2,
    input  logic [1:0] winner,
    output logic       led1_r,
    output logic       led1_g,
    output logic       led1_b,
    output logic       led2_r,
    output logic       led2_g,
    output logic       led2_b,
    output logic [6:0] seg,
    output logic [7:0] digit_pos,
    output logic       lcd_e,
    output logic       lcd_rs,
    output logic       lcd_rw,
    output logic [7:0] lcd_data
);

    logic  line_sel;
    col_t  column;
    char_t char_code;

    assign lcd_rw = 1'b0; // Write only

    led_indicator u_led_indicator (
        .clk    (clk),
        .resetn (resetn),
        .pick1  (pick_t'(pick1)),
        .pick2  (pick_t'(pick2)),
        .led1_r (led1_r),
        .led1_g (led1_g),
        .led1_b (led1_b),
        .led2_r (led2_r),
        .led2_g (led2_g),
        .led2_b (led2_b)
    );

    score_scanner u_score_scanner (
        .clk       (clk),
        .resetn    (resetn),
        .score1    (score1),
        .score2    (score2),
        .seg       (seg),
        .digit_pos (digit_pos)
    );

    lcd_banner u_lcd_banner (
        .winner    (winner_t'(winner)),
        .line_sel  (line_sel),
        .column    (column),
        .char_code (char_code)
    );

    lcd_sequencer #(
        .POWER_WAIT_CYCLES (POWER_WAIT_CYCLES),
        .CMD_CYCLES        (CMD_CYCLES),
        .LINE_CYCLES       (LINE_CYCLES),
        .HOME_CYCLES       (HOME_CYCLES),
        .CLEAR_CYCLES      (CLEAR_CYCLES)
    ) u_lcd_sequencer (
        .clk       (clk),
        .resetn    (resetn),
        .char_code (char_code),
        .line_sel  (line_sel),
        .column    (column),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_data  (lcd_data)
    );

endmodule

// File: bench/tb_game_panel.sv
`timescale 1ns/10ps

module tb_game_panel
    import panel_pkg::*;
    import lcd_pkg::*;
();

    localparam int          CLK_HALF      = 20;
    localparam int          DRIVE_DELAY   = 2;
    localparam int          WRITE_TIMEOUT = 100; // Cycles allowed between LCD writes
    localparam int          DIGIT_TIMEOUT = 16;
    localparam int          SYNC_WRITES   = 80;
    localparam int          RUN_LIMIT     = 6000;
    localparam logic [31:0] RAND_SEED     = 32'h65c670e9;

    logic       clk;
    logic       resetn;
    logic [1:0] pick1;
    logic [1:0] pick2;
    logic [2:0] score1;
    logic [2:0] score2;
    logic [1:0] winner;
    logic       led1_r;
    logic       led1_g;
    logic       led1_b;
    logic       led2_r;
    logic       led2_g;
    logic       led2_b;
    logic [6:0] seg;
    logic [7:0] digit_pos;
    logic       lcd_e;
    logic       lcd_rs;
    logic       lcd_rw;
    logic [7:0] lcd_data;

    logic [2:0] led1_exp;
    logic [2:0] led2_exp;
    int         mismatch_count;
    int         timeout_count;

    game_panel_top #(
        .POWER_WAIT_CYCLES (8),
        .CMD_CYCLES        (4),
        .LINE_CYCLES       (20),
        .HOME_CYCLES       (6),
        .CLEAR_CYCLES      (5)
    ) dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .pick1     (pick1),
        .pick2     (pick2),
        .score1    (score1),
        .score2    (score2),
        .winner    (winner),
        .led1_r    (led1_r),
        .led1_g    (led1_g),
        .led1_b    (led1_b),
        .led2_r    (led2_r),
        .led2_g    (led2_g),
        .led2_b    (led2_b),
        .seg       (seg),
        .digit_pos (digit_pos),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic log_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic log_timeout(input string msg);
        timeout_count++;
        $display("Timeout at %0t ns: %s", $time, msg);
    endtask

    assert property (@(posedge clk) lcd_rw == 1'b0)
        else log_mismatch("lcd_rw is not held low");

    assert property (@(posedge clk) disable iff (!resetn)
        digit_pos == 8'h00 || digit_pos == DIGIT_POS_P1 || digit_pos == DIGIT_POS_P2)
        else log_mismatch($sformatf("illegal digit_pos %h", digit_pos));

    function automatic logic [2:0] expected_rgb(input logic [1:0] pick);
        case (pick)
            2'd1:    return 3'b100;
            2'd2:    return 3'b010;
            2'd3:    return 3'b001;
            default: return 3'b000;
        endcase
    endfunction

    // Segment a in the top bit
    function automatic logic [6:0] expected_segments(input logic [2:0] score);
        case (score)
            3'd1:    return 7'b0110000;
            3'd2:    return 7'b1101101;
            3'd3:    return 7'b1111001;
            3'd4:    return 7'b0110011;
            3'd5:    return 7'b1011011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic logic [7:0] expected_char(input logic [1:0] who, input int line,
                                                 input int col);
        string text;
        text = $sformatf("P%0d Win", who);
        if (who != 2'd1 && who != 2'd2) return CHAR_SPACE;
        if (line == 0) begin
            if (col >= 2 && col <= 7) return text[col - 2]; // Banner text from column 2
            return CHAR_SPACE;
        end
        if ((col >= 2 && col <= 4) || (col >= 6 && col <= 8)) return CHAR_HEART;
        return CHAR_SPACE;
    endfunction

    task automatic apply_picks(input logic [1:0] p1, input logic [1:0] p2);
        @(posedge clk);
        #DRIVE_DELAY;
        pick1 = p1;
        pick2 = p2;
        if ((p1 != 2'd0) != (p2 != 2'd0)) begin
            led1_exp = expected_rgb(p1);
            led2_exp = expected_rgb(p2);
        end
        @(posedge clk);
        @(negedge clk);
        assert ({led1_r, led1_g, led1_b} === led1_exp && {led2_r, led2_g, led2_b} === led2_exp)
            else log_mismatch($sformatf("picks %0d/%0d gave LEDs %b %b, expected %b %b",
                p1, p2, {led1_r, led1_g, led1_b}, {led2_r, led2_g, led2_b}, led1_exp, led2_exp));
    endtask

    task automatic show_scores(input logic [2:0] s1, input logic [2:0] s2);
        int   waited;
        logic seen1;
        logic seen2;
        @(posedge clk);
        #DRIVE_DELAY;
        score1 = s1;
        score2 = s2;
        @(posedge clk); // First slot registered with the new scores
        waited = 0;
        seen1  = 1'b0;
        seen2  = 1'b0;
        while (!(seen1 && seen2) && waited < DIGIT_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (digit_pos == DIGIT_POS_P1) begin
                seen1 = 1'b1;
                assert (seg === expected_segments(s1))
                    else log_mismatch($sformatf("score1 %0d shows seg %b", s1, seg));
            end else if (digit_pos == DIGIT_POS_P2) begin
                seen2 = 1'b1;
                assert (seg === expected_segments(s2))
                    else log_mismatch($sformatf("score2 %0d shows seg %b", s2, seg));
            end else if (digit_pos == 8'h00) begin
                assert (seg === 7'b0) else log_mismatch($sformatf("blank slot seg %b", seg));
            end
        end
        if (!(seen1 && seen2)) log_timeout("both score digits were not shown");
    endtask

    task automatic next_write(output logic rs, output logic [7:0] data);
        int   waited;
        logic seen;
        rs     = 1'b0;
        data   = 8'h00;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WRITE_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (lcd_e) begin
                seen = 1'b1;
                rs   = lcd_rs;
                data = lcd_data;
            end
        end
        if (!seen) log_timeout("no LCD write strobe seen");
    endtask

    task automatic expect_write(input logic exp_rs, input logic [7:0] exp_data,
                                input string what);
        logic       rs;
        logic [7:0] data;
        next_write(rs, data);
        assert (rs === exp_rs && data === exp_data)
            else log_mismatch($sformatf("%s: got rs=%b data=%h, expected rs=%b data=%h",
                what, rs, data, exp_rs, exp_data));
    endtask

    // Frame starts after its line 1 address and ends with the next one
    task automatic check_frame(input logic [1:0] who);
        for (int line = 0; line < 2; line++) begin
            if (line == 1) expect_write(1'b0, CMD_LINE2_ADDR, "line 2 address");
            for (int col = 0; col < LCD_COLS; col++) begin
                expect_write(1'b1, expected_char(who, line, col),
                             $sformatf("winner %0d line %0d col %0d", who, line, col));
            end
        end
        expect_write(1'b0, CMD_RETURN_HOME, "return home");
        expect_write(1'b0, CMD_CLEAR, "clear");
        expect_write(1'b0, CMD_LINE1_ADDR, "line 1 address");
    endtask

    task automatic show_banner(input logic [1:0] who, input int frames);
        logic       rs;
        logic [7:0] data;
        int         count;
        logic       found;
        @(posedge clk);
        #DRIVE_DELAY;
        winner = who;
        count  = 0;
        found  = 1'b0;
        while (!found && count < SYNC_WRITES) begin // Skip the frame already in progress
            next_write(rs, data);
            count++;
            found = (rs == 1'b0 && data == CMD_LINE1_ADDR);
        end
        if (!found) log_timeout("line 1 address write never came");
        repeat (frames) check_frame(who);
    endtask

    initial begin
        mismatch_count = 0;
        timeout_count  = 0;
        resetn   = 1'b0;
        pick1    = 2'd0;
        pick2    = 2'd0;
        score1   = 3'd0;
        score2   = 3'd0;
        winner   = WIN_NONE;
        led1_exp = 3'b000;
        led2_exp = 3'b000;
        void'($urandom(RAND_SEED));
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        @(negedge clk);
        assert ({led1_r, led1_g, led1_b, led2_r, led2_g, led2_b} === 6'b0)
            else log_mismatch("LEDs not dark after reset");
        assert (seg === 7'b0 && digit_pos === 8'h00)
            else log_mismatch("seven-segment outputs not zero after reset");
        assert (lcd_e === 1'b0 && lcd_rs === 1'b0 && lcd_data === 8'h00)
            else log_mismatch("LCD bus not idle after reset");
        fork
            begin
                apply_picks(2'd1, 2'd0);
                apply_picks(2'd0, 2'd0);
                apply_picks(2'd3, 2'd2);
                apply_picks(2'd0, 2'd3);
                repeat (40) apply_picks(2'($urandom()), 2'($urandom()));
                show_scores(3'd0, 3'd6);
                show_scores(3'd7, 3'd3);
                repeat (10) show_scores(3'($urandom()), 3'($urandom()));
            end
            begin
                expect_write(1'b0, CMD_FUNC_SET, "function set");
                expect_write(1'b0, CMD_ENTRY_MODE, "entry mode");
                expect_write(1'b0, CMD_DISPLAY_ON, "display on");
                expect_write(1'b0, CMD_LINE1_ADDR, "first line 1 address");
                show_banner(WIN_P1, 2);
                show_banner(WIN_P2, 2);
                show_banner(WIN_NONE, 2);
                show_banner(2'd3, 1);
            end
        join
        repeat (2) @(posedge clk);
        $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run did not finish within %0d cycles", RUN_LIMIT);
        $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count + 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: all.f
logic/panel_pkg.sv
logic/lcd_pkg.sv
logic/led_indicator.sv
logic/score_scanner.sv
logic/lcd_banner.sv
logic/lcd_sequencer.sv
logic/game_panel_top.sv
bench/tb_game_panel.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= tb_game_panel
FILELIST  ?= all.f
PASS_MSG  := PASS: all tests

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
